// File: src.f
+incdir+include
src/csr_pkg.sv
src/exc_pkg.sv
src/csr_access.sv
src/exc_state_regs.sv
src/timer_unit.sv
src/int_ctrl.sv
src/csr_top.sv
tb/csr_properties.sv
tb/csr_tb.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the CSR testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --assert --top-module csr_tb -Mdir obj_dir -f src.f
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/Vcsr_tb > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -qx "Everything OK" sim.log; then
    exit 0
fi
exit 1

// File: tb/csr_tb.sv
`timescale 1ns/10ps
`default_nettype none

`include "csr_settings.svh"

module csr_tb;

    logic                     clk;
    logic                     reset;
    csr_pkg::csr_num_t        csr_num;
    logic                     csr_we;
    csr_pkg::csr_word_t       csr_wmask;
    csr_pkg::csr_word_t       csr_wvalue;
    logic                     wb_ex;
    exc_pkg::ecode_e          wb_ecode;
    exc_pkg::esubcode_t       wb_esubcode;
    csr_pkg::csr_word_t       wb_pc;
    logic                     ertn_flush;
    logic [`CSR_HW_INT_W-1:0] hw_int_in;
    logic                     ipi_int_in;
    csr_pkg::csr_word_t       csr_rvalue;
    csr_pkg::csr_word_t       ex_entry;
    logic                     has_int;

    // Reference model of the kept registers
    csr_pkg::plv_t      m_plv;
    logic               m_ie;
    csr_pkg::plv_t      m_pplv;
    logic               m_pie;
    csr_pkg::csr_word_t m_era;
    csr_pkg::csr_word_t m_eentry;
    csr_pkg::csr_word_t m_save [4];
    exc_pkg::ecode_e    m_ecode;
    exc_pkg::esubcode_t m_esub;
    csr_pkg::irq_vec_t  m_lie;
    csr_pkg::irq_vec_t  m_is;
    csr_pkg::csr_word_t m_tcfg;
    csr_pkg::csr_word_t m_tval;

    // Requests from stimulus to the compare process
    logic               chk_word;
    logic               chk_flag;
    logic               chk_trend;
    string              chk_name;
    csr_pkg::csr_word_t exp_word;
    logic               exp_flag;
    csr_pkg::csr_word_t last_tval = '0;

    int          checks = 0;
    int          errors = 0;
    int          timeouts = 0;
    logic [31:0] lfsr_state;

    exc_pkg::ecode_e code_list [15] = '{exc_pkg::INT, exc_pkg::PIL, exc_pkg::PIS,
        exc_pkg::PIF, exc_pkg::PME, exc_pkg::PPI, exc_pkg::ADE, exc_pkg::ALE, exc_pkg::SYS,
        exc_pkg::BRK, exc_pkg::INE, exc_pkg::IPE, exc_pkg::FPD, exc_pkg::FPE, exc_pkg::TLBR};
    csr_pkg::csr_num_t store_list [6] = '{`CSR_ADDR_SAVE0, `CSR_ADDR_SAVE0 + 14'd1,
        `CSR_ADDR_SAVE0 + 14'd2, `CSR_ADDR_SAVE0 + 14'd3, `CSR_ADDR_ERA, `CSR_ADDR_EENTRY};
    csr_pkg::csr_num_t kept_list [13] = '{`CSR_ADDR_CRMD, `CSR_ADDR_PRMD, `CSR_ADDR_ECFG,
        `CSR_ADDR_ESTAT, `CSR_ADDR_ERA, `CSR_ADDR_EENTRY, `CSR_ADDR_SAVE0,
        `CSR_ADDR_SAVE0 + 14'd1, `CSR_ADDR_SAVE0 + 14'd2, `CSR_ADDR_SAVE0 + 14'd3,
        `CSR_ADDR_TCFG, `CSR_ADDR_TVAL, `CSR_ADDR_TICLR};

    csr_top dut0 (
        .clk         (clk),
        .reset       (reset),
        .csr_num     (csr_num),
        .csr_we      (csr_we),
        .csr_wmask   (csr_wmask),
        .csr_wvalue  (csr_wvalue),
        .wb_ex       (wb_ex),
        .wb_ecode    (wb_ecode),
        .wb_esubcode (wb_esubcode),
        .wb_pc       (wb_pc),
        .ertn_flush  (ertn_flush),
        .hw_int_in   (hw_int_in),
        .ipi_int_in  (ipi_int_in),
        .csr_rvalue  (csr_rvalue),
        .ex_entry    (ex_entry),
        .has_int     (has_int)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // Galois LFSR, one step per bit taken
    function automatic csr_pkg::csr_word_t take_bits(input int n);
        csr_pkg::csr_word_t r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_state[0] ? (lfsr_state >> 1) ^ 32'h8020_0003 : lfsr_state >> 1;
            r = {r[30:0], lfsr_state[0]};
        end
        return r;
    endfunction

    function automatic csr_pkg::csr_word_t merge_ref(input csr_pkg::csr_word_t old_val,
                                                     input csr_pkg::csr_word_t new_val,
                                                     input csr_pkg::csr_word_t mask);
        return (old_val & ~mask) | (new_val & mask);
    endfunction

    // Expected read word for an address
    function automatic csr_pkg::csr_word_t expected_read(input csr_pkg::csr_num_t num);
        case (num)
            `CSR_ADDR_CRMD:          return {29'b0, m_ie, m_plv};
            `CSR_ADDR_PRMD:          return {29'b0, m_pie, m_pplv};
            `CSR_ADDR_ECFG:          return {19'b0, m_lie};
            `CSR_ADDR_ESTAT:         return {1'b0, m_esub, m_ecode, 3'b0, m_is};
            `CSR_ADDR_ERA:           return m_era;
            `CSR_ADDR_EENTRY:        return m_eentry;
            `CSR_ADDR_SAVE0:         return m_save[0];
            `CSR_ADDR_SAVE0 + 14'd1: return m_save[1];
            `CSR_ADDR_SAVE0 + 14'd2: return m_save[2];
            `CSR_ADDR_SAVE0 + 14'd3: return m_save[3];
            `CSR_ADDR_TCFG:          return m_tcfg;
            `CSR_ADDR_TVAL:          return m_tval;
            default:                 return '0;
        endcase
    endfunction

    task automatic apply_write(input csr_pkg::csr_num_t num, input csr_pkg::csr_word_t mask,
                               input csr_pkg::csr_word_t val);
        csr_pkg::csr_word_t nv;
        nv = merge_ref(expected_read(num), val, mask);
        case (num)
            `CSR_ADDR_CRMD: begin
                m_plv = nv[1:0];
                m_ie  = nv[2];
            end
            `CSR_ADDR_PRMD: begin
                m_pplv = nv[1:0];
                m_pie  = nv[2];
            end
            `CSR_ADDR_ECFG:          m_lie = nv[12:0];
            `CSR_ADDR_ERA:           m_era = nv;
            `CSR_ADDR_EENTRY:        m_eentry = {nv[31:6], 6'b0};
            `CSR_ADDR_SAVE0:         m_save[0] = nv;
            `CSR_ADDR_SAVE0 + 14'd1: m_save[1] = nv;
            `CSR_ADDR_SAVE0 + 14'd2: m_save[2] = nv;
            `CSR_ADDR_SAVE0 + 14'd3: m_save[3] = nv;
            `CSR_ADDR_TCFG:          m_tcfg = nv;
            default: ;
        endcase
    endtask

    task automatic check_word(input string name, input csr_pkg::csr_word_t got,
                              input csr_pkg::csr_word_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("[FAIL] %0t %s: got %h, expected %h", $time, name, got, exp);
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("[FAIL] %0t %s: got %b, expected %b", $time, name, got, exp);
        end
    endtask

    task automatic check_ecode(input string name, input exc_pkg::ecode_e got,
                               input exc_pkg::ecode_e exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("[FAIL] %0t %s: got %h, expected %h", $time, name, got, exp);
        end
    endtask

    // Compare at the falling edge, half a cycle after inputs settle
    always @(negedge clk) begin
        if (!reset) begin
            check_word("ex_entry", ex_entry, m_eentry);
            if (chk_word) begin
                check_word(chk_name, csr_rvalue, exp_word);
                if (csr_num == `CSR_ADDR_ESTAT)
                    check_ecode("ESTAT.Ecode", exc_pkg::ecode_e'(csr_rvalue[21:16]), m_ecode);
                if (csr_num == `CSR_ADDR_TVAL) begin
                    if (chk_trend)
                        check_flag("TVAL decreasing", csr_rvalue < last_tval, 1'b1);
                    last_tval = csr_rvalue;
                end
            end
            if (chk_flag)
                check_flag("has_int", has_int, exp_flag);
        end
    end

    task automatic tick();
        @(posedge clk);
        #1;
    endtask

    task automatic write_reg(input csr_pkg::csr_num_t num, input csr_pkg::csr_word_t mask,
                             input csr_pkg::csr_word_t val);
        csr_num    = num;
        csr_we     = 1'b1;
        csr_wmask  = mask;
        csr_wvalue = val;
        tick();
        csr_we = 1'b0;
        apply_write(num, mask, val);
    endtask

    task automatic read_reg(input csr_pkg::csr_num_t num);
        csr_num  = num;
        exp_word = expected_read(num);
        chk_name = $sformatf("csr_rvalue@%h", num);
        chk_word = 1'b1;
        tick();
        chk_word = 1'b0;
    endtask

    task automatic wait_has_int(input logic exp, input int limit, input string what);
        int n;
        n = 0;
        while (has_int !== exp && n < limit) begin
            tick();
            n++;
        end
        if (has_int !== exp) begin
            timeouts++;
            $display("Timeout: has_int never reached %b after %s", exp, what);
        end
        exp_flag = exp;
        chk_flag = 1'b1;
        tick();
        chk_flag = 1'b0;
    endtask

    initial begin
        int                 sel;
        int                 line;
        csr_pkg::csr_word_t tmp;
        csr_pkg::csr_word_t start;

        reset       = 1'b1;
        csr_num     = '0;
        csr_we      = 1'b0;
        csr_wmask   = '0;
        csr_wvalue  = '0;
        wb_ex       = 1'b0;
        wb_ecode    = exc_pkg::INT;
        wb_esubcode = '0;
        wb_pc       = '0;
        ertn_flush  = 1'b0;
        hw_int_in   = '0;
        ipi_int_in  = 1'b0;
        chk_word    = 1'b0;
        chk_flag    = 1'b0;
        chk_trend   = 1'b0;
        chk_name    = "";
        exp_word    = '0;
        exp_flag    = 1'b0;
        lfsr_state  = 32'h7e2b;
        m_plv       = '0;
        m_ie        = 1'b0;
        m_pplv      = '0;
        m_pie       = 1'b0;
        m_era       = '0;
        m_eentry    = '0;
        m_save      = '{default: '0};
        m_ecode     = exc_pkg::INT;
        m_esub      = '0;
        m_lie       = '0;
        m_is        = '0;
        m_tcfg      = '0;
        m_tval      = `CSR_TIMER_IDLE;
        repeat (16) @(posedge clk);
        #1;
        reset = 1'b0;
        tick();

        // Masked writes to plain storage
        for (int i = 0; i < 24; i++) begin
            sel = int'(take_bits(3)) % 6;
            write_reg(store_list[sel], take_bits(32), take_bits(32));
            read_reg(store_list[sel]);
        end

        // Exception entry and return
        for (int i = 0; i < 4; i++) begin
            write_reg(`CSR_ADDR_CRMD, 32'h7, take_bits(3));
            tmp         = take_bits(9);
            wb_ex       = 1'b1;
            wb_pc       = take_bits(32);
            wb_ecode    = code_list[int'(take_bits(4)) % 15];
            wb_esubcode = tmp[8:0];
            tick();
            wb_ex  = 1'b0;
            m_pplv = m_plv;
            m_pie  = m_ie;
            m_plv  = '0;
            m_ie   = 1'b0;
            m_era  = wb_pc;
            m_ecode = wb_ecode;
            m_esub = wb_esubcode;
            read_reg(`CSR_ADDR_ERA);
            read_reg(`CSR_ADDR_ESTAT);
            read_reg(`CSR_ADDR_CRMD);
            read_reg(`CSR_ADDR_PRMD);
            ertn_flush = 1'b1;
            tick();
            ertn_flush = 1'b0;
            m_plv = m_pplv;
            m_ie  = m_pie;
            read_reg(`CSR_ADDR_CRMD);
        end

        // Hardware interrupt line through LIE and IE
        line = int'(take_bits(3));
        write_reg(`CSR_ADDR_ECFG, 32'hffff_ffff, 32'd1 << (line + 2));
        write_reg(`CSR_ADDR_CRMD, 32'h4, 32'h4);
        hw_int_in[line] = 1'b1;
        m_is = csr_pkg::irq_vec_t'(32'd1 << (line + 2));
        wait_has_int(1'b1, 10, "raising a hw line");
        read_reg(`CSR_ADDR_ESTAT);
        write_reg(`CSR_ADDR_CRMD, 32'h4, 32'h0);
        wait_has_int(1'b0, 10, "clearing IE");
        write_reg(`CSR_ADDR_CRMD, 32'h4, 32'h4);
        wait_has_int(1'b1, 10, "setting IE again");
        write_reg(`CSR_ADDR_ECFG, 32'hffff_ffff, 32'h0);
        wait_has_int(1'b0, 10, "disabling the LIE bit");
        hw_int_in = '0;
        m_is = '0;
        tick();

        // One-shot timer
        write_reg(`CSR_ADDR_ECFG, 32'hffff_ffff, 32'd1 << `CSR_IS_TIMER_BIT);
        start = csr_pkg::csr_word_t'(20 + int'(take_bits(4))) << 2;
        write_reg(`CSR_ADDR_TCFG, 32'hffff_ffff, start | 32'd1);
        m_tval = start;
        read_reg(`CSR_ADDR_TVAL);
        repeat (3) tick();
        m_tval = start - 32'd4;
        chk_trend = 1'b1;
        read_reg(`CSR_ADDR_TVAL);
        chk_trend = 1'b0;
        wait_has_int(1'b1, 200, "starting a one-shot timer");
        m_is[`CSR_IS_TIMER_BIT] = 1'b1;
        m_tval = `CSR_TIMER_IDLE;
        read_reg(`CSR_ADDR_ESTAT);
        read_reg(`CSR_ADDR_TVAL);
        write_reg(`CSR_ADDR_TICLR, 32'h1, 32'h1);
        m_is = '0;
        read_reg(`CSR_ADDR_ESTAT);
        wait_has_int(1'b0, 10, "a TICLR write");

        // Unmapped address leaves the map untouched
        tmp = 32'h100 | take_bits(6);
        write_reg(tmp[13:0], take_bits(32), take_bits(32));
        read_reg(tmp[13:0]);
        for (int i = 0; i < 13; i++)
            read_reg(kept_list[i]);

        $display("Checks: %0d, errors: %0d, timeouts: %0d", checks, errors, timeouts);
        if (errors == 0 && timeouts == 0)
            $display("Everything OK");
        else
            $display("Something failed");
        $finish;
    end

endmodule

`default_nettype wire

// File: tb/csr_properties.sv
`timescale 1ns/10ps
`default_nettype none

`include "csr_settings.svh"

module csr_properties (
    input logic               clk,
    input logic               reset,
    input csr_pkg::csr_num_t  csr_num,
    input logic               csr_we,
    input csr_pkg::csr_word_t csr_rvalue,
    input csr_pkg::csr_word_t ex_entry,
    input logic               has_int
);

    logic kept_addr;
    logic eentry_wr;

    assign kept_addr = (csr_num == `CSR_ADDR_CRMD)  || (csr_num == `CSR_ADDR_PRMD)  ||
                       (csr_num == `CSR_ADDR_ECFG)  || (csr_num == `CSR_ADDR_ESTAT) ||
                       (csr_num == `CSR_ADDR_ERA)   || (csr_num == `CSR_ADDR_EENTRY) ||
                       (csr_num == `CSR_ADDR_SAVE0) ||
                       (csr_num == `CSR_ADDR_SAVE0 + 14'd1) ||
                       (csr_num == `CSR_ADDR_SAVE0 + 14'd2) ||
                       (csr_num == `CSR_ADDR_SAVE0 + 14'd3) ||
                       (csr_num == `CSR_ADDR_TCFG)  || (csr_num == `CSR_ADDR_TVAL)  ||
                       (csr_num == `CSR_ADDR_TICLR);

    assign eentry_wr = csr_we && (csr_num == `CSR_ADDR_EENTRY);

    // Registers are cleared by the reset edge
    has_int_low_in_reset: assert property (@(posedge clk) reset |=> !has_int)
        else $error("has_int high right after a reset cycle");

    // Entry address moves only after a software write to EENTRY
    entry_aligned: assert property (@(posedge clk) disable iff (reset)
        ex_entry[5:0] == 6'b0 && ($stable(ex_entry) || $past(eentry_wr)))
        else $error("ex_entry misaligned or changed without an EENTRY write");

    unknown_reads_zero: assert property (@(posedge clk) disable iff (reset)
        !kept_addr |-> csr_rvalue == '0)
        else $error("nonzero read from an unmapped address");

endmodule

bind csr_top csr_properties props0 (
    .clk        (clk),
    .reset      (reset),
    .csr_num    (csr_num),
    .csr_we     (csr_we),
    .csr_rvalue (csr_rvalue),
    .ex_entry   (ex_entry),
    .has_int    (has_int)
);

`default_nettype wire

// File: src/csr_top.sv
`timescale 1ns/10ps
`default_nettype none

`include "csr_settings.svh"

module csr_top (
    input  logic                     clk,
    input  logic                     reset,
    input  csr_pkg::csr_num_t        csr_num,
    input  logic                     csr_we,
    input  csr_pkg::csr_word_t       csr_wmask,
    input  csr_pkg::csr_word_t       csr_wvalue,
    input  logic                     wb_ex,
    input  exc_pkg::ecode_e          wb_ecode,
    input  exc_pkg::esubcode_t       wb_esubcode,
    input  csr_pkg::csr_word_t       wb_pc,
    input  logic                     ertn_flush,
    input  logic [`CSR_HW_INT_W-1:0] hw_int_in,
    input  logic                     ipi_int_in,
    output csr_pkg::csr_word_t       csr_rvalue,
    output csr_pkg::csr_word_t       ex_entry,
    output logic                     has_int
);

    csr_pkg::csr_id_e   csr_id;
    logic               wr_en;
    logic               crmd_ie;
    logic               timer_hit;
    csr_pkg::csr_word_t crmd_rd;
    csr_pkg::csr_word_t prmd_rd;
    csr_pkg::csr_word_t ecfg_rd;
    csr_pkg::csr_word_t estat_rd;
    csr_pkg::csr_word_t era_rd;
    csr_pkg::csr_word_t eentry_rd;
    csr_pkg::csr_word_t save_rd [4];
    csr_pkg::csr_word_t tcfg_rd;
    csr_pkg::csr_word_t tval_rd;
    csr_pkg::irq_vec_t  is_rd;
    exc_pkg::ecode_e    ecode_rd;
    exc_pkg::esubcode_t esubcode_rd;

    // ESTAT layout: EsubCode 30:22, Ecode 21:16, IS 12:0
    assign estat_rd = {1'b0, esubcode_rd, ecode_rd, 3'b0, is_rd};

    csr_access u_access (
        .csr_num    (csr_num),
        .csr_we     (csr_we),
        .crmd_rd    (crmd_rd),
        .prmd_rd    (prmd_rd),
        .ecfg_rd    (ecfg_rd),
        .estat_rd   (estat_rd),
        .era_rd     (era_rd),
        .eentry_rd  (eentry_rd),
        .save_rd    (save_rd),
        .tcfg_rd    (tcfg_rd),
        .tval_rd    (tval_rd),
        .csr_id     (csr_id),
        .wr_en      (wr_en),
        .csr_rvalue (csr_rvalue)
    );

    exc_state_regs u_exc (
        .clk         (clk),
        .reset       (reset),
        .csr_id      (csr_id),
        .wr_en       (wr_en),
        .csr_wmask   (csr_wmask),
        .csr_wvalue  (csr_wvalue),
        .wb_ex       (wb_ex),
        .wb_ecode    (wb_ecode),
        .wb_esubcode (wb_esubcode),
        .wb_pc       (wb_pc),
        .ertn_flush  (ertn_flush),
        .crmd_ie     (crmd_ie),
        .crmd_rd     (crmd_rd),
        .prmd_rd     (prmd_rd),
        .era_rd      (era_rd),
        .eentry_rd   (eentry_rd),
        .ex_entry    (ex_entry),
        .save_rd     (save_rd),
        .ecode_rd    (ecode_rd),
        .esubcode_rd (esubcode_rd)
    );

    timer_unit u_timer (
        .clk        (clk),
        .reset      (reset),
        .csr_id     (csr_id),
        .wr_en      (wr_en),
        .csr_wmask  (csr_wmask),
        .csr_wvalue (csr_wvalue),
        .tcfg_rd    (tcfg_rd),
        .tval_rd    (tval_rd),
        .timer_hit  (timer_hit)
    );

    int_ctrl u_int (
        .clk        (clk),
        .reset      (reset),
        .csr_id     (csr_id),
        .wr_en      (wr_en),
        .csr_wmask  (csr_wmask),
        .csr_wvalue (csr_wvalue),
        .hw_int_in  (hw_int_in),
        .ipi_int_in (ipi_int_in),
        .timer_hit  (timer_hit),
        .crmd_ie    (crmd_ie),
        .ecfg_rd    (ecfg_rd),
        .is_rd      (is_rd),
        .has_int    (has_int)
    );

endmodule

`default_nettype wire

// File: src/int_ctrl.sv
`timescale 1ns/10ps
`default_nettype none

`include "csr_settings.svh"

module int_ctrl (
    input  logic                      clk,
    input  logic                      reset,
    input  csr_pkg::csr_id_e          csr_id,
    input  logic                      wr_en,
    input  csr_pkg::csr_word_t        csr_wmask,
    input  csr_pkg::csr_word_t        csr_wvalue,
    input  logic [`CSR_HW_INT_W-1:0]  hw_int_in,
    input  logic                      ipi_int_in,
    input  logic                      timer_hit,
    input  logic                      crmd_ie,
    output csr_pkg::csr_word_t        ecfg_rd,
    output csr_pkg::irq_vec_t         is_rd,
    output logic                      has_int
);

    csr_pkg::irq_vec_t  lie;
    csr_pkg::irq_vec_t  is_q;
    csr_pkg::csr_word_t ecfg_wr_val;
    csr_pkg::csr_word_t estat_wr_val;
    logic               ticlr_hit;

    assign ecfg_rd      = {19'b0, lie};
    assign is_rd        = is_q;
    assign ecfg_wr_val  = csr_pkg::mask_merge(ecfg_rd, csr_wvalue, csr_wmask);
    assign estat_wr_val = csr_pkg::mask_merge({19'b0, is_q}, csr_wvalue, csr_wmask);
    assign ticlr_hit    = wr_en && csr_id == csr_pkg::ID_TICLR && csr_wmask[0] && csr_wvalue[0];

    // LIE bit 10 is reserved
    always_ff @(posedge clk) begin
        if (reset)
            lie <= '0;
        else if (wr_en && csr_id == csr_pkg::ID_ECFG)
            lie <= ecfg_wr_val[12:0] & 13'h1bff;
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            is_q <= '0;
        end else begin
            if (wr_en && csr_id == csr_pkg::ID_ESTAT)
                is_q[1:0] <= estat_wr_val[1:0];
            is_q[9:2]  <= hw_int_in;
            is_q[10]   <= 1'b0;
            if (timer_hit)
                is_q[`CSR_IS_TIMER_BIT] <= 1'b1;
            else if (ticlr_hit)
                is_q[`CSR_IS_TIMER_BIT] <= 1'b0;
            is_q[`CSR_IS_IPI_BIT] <= ipi_int_in;
        end
    end

    assign has_int = (|(lie & is_q)) && crmd_ie;

endmodule

`default_nettype wire

// File: src/timer_unit.sv
`timescale 1ns/10ps
`default_nettype none

`include "csr_settings.svh"

module timer_unit (
    input  logic               clk,
    input  logic               reset,
    input  csr_pkg::csr_id_e   csr_id,
    input  logic               wr_en,
    input  csr_pkg::csr_word_t csr_wmask,
    input  csr_pkg::csr_word_t csr_wvalue,
    output csr_pkg::csr_word_t tcfg_rd,
    output csr_pkg::csr_word_t tval_rd,
    output logic               timer_hit
);

    logic               tcfg_en;
    logic               tcfg_periodic;
    logic [29:0]        tcfg_initval;
    csr_pkg::csr_word_t timer_cnt;
    csr_pkg::csr_word_t tcfg_next;
    logic               tcfg_wr;

    assign tcfg_rd   = {tcfg_initval, tcfg_periodic, tcfg_en};
    assign tval_rd   = timer_cnt;
    assign timer_hit = (timer_cnt == '0);

    assign tcfg_wr   = wr_en && (csr_id == csr_pkg::ID_TCFG);
    assign tcfg_next = csr_pkg::mask_merge(tcfg_rd, csr_wvalue, csr_wmask);

    always_ff @(posedge clk) begin
        if (reset)
            tcfg_en <= 1'b0;
        else if (tcfg_wr)
            tcfg_en <= tcfg_next[0];
        if (tcfg_wr) begin
            tcfg_periodic <= tcfg_next[1];
            tcfg_initval  <= tcfg_next[31:2];
        end
    end

    // One-shot wraps from zero to idle and stops there
    always_ff @(posedge clk) begin
        if (reset) begin
            timer_cnt <= `CSR_TIMER_IDLE;
        end else if (tcfg_wr && tcfg_next[0]) begin
            timer_cnt <= {tcfg_next[31:2], 2'b0};
        end else if (tcfg_en && timer_cnt != `CSR_TIMER_IDLE) begin
            if (timer_hit && tcfg_periodic)
                timer_cnt <= {tcfg_initval, 2'b0};
            else
                timer_cnt <= timer_cnt - 32'd1;
        end
    end

endmodule

`default_nettype wire

// File: src/exc_state_regs.sv
`timescale 1ns/10ps
`default_nettype none

module exc_state_regs (
    input  logic                 clk,
    input  logic                 reset,
    input  csr_pkg::csr_id_e     csr_id,
    input  logic                 wr_en,
    input  csr_pkg::csr_word_t   csr_wmask,
    input  csr_pkg::csr_word_t   csr_wvalue,
    input  logic                 wb_ex,
    input  exc_pkg::ecode_e      wb_ecode,
    input  exc_pkg::esubcode_t   wb_esubcode,
    input  csr_pkg::csr_word_t   wb_pc,
    input  logic                 ertn_flush,
    output logic                 crmd_ie,
    output csr_pkg::csr_word_t   crmd_rd,
    output csr_pkg::csr_word_t   prmd_rd,
    output csr_pkg::csr_word_t   era_rd,
    output csr_pkg::csr_word_t   eentry_rd,
    output csr_pkg::csr_word_t   ex_entry,
    output csr_pkg::csr_word_t   save_rd [4],
    output exc_pkg::ecode_e      ecode_rd,
    output exc_pkg::esubcode_t   esubcode_rd
);

    csr_pkg::plv_t      crmd_plv;
    csr_pkg::plv_t      prmd_pplv;
    logic               prmd_pie;
    csr_pkg::csr_word_t era_q;
    logic [25:0]        eentry_va;
    csr_pkg::csr_word_t save_q [4];
    csr_pkg::csr_word_t crmd_wr_val;
    csr_pkg::csr_word_t prmd_wr_val;
    csr_pkg::csr_word_t eentry_wr_val;

    assign crmd_rd   = {29'b0, crmd_ie, crmd_plv};
    assign prmd_rd   = {29'b0, prmd_pie, prmd_pplv};
    assign era_rd    = era_q;
    assign eentry_rd = {eentry_va, 6'b0};
    assign ex_entry  = eentry_rd;
    assign save_rd   = save_q;

    assign crmd_wr_val   = csr_pkg::mask_merge(crmd_rd, csr_wvalue, csr_wmask);
    assign prmd_wr_val   = csr_pkg::mask_merge(prmd_rd, csr_wvalue, csr_wmask);
    assign eentry_wr_val = csr_pkg::mask_merge(eentry_rd, csr_wvalue, csr_wmask);

    // Exception entry beats ertn, ertn beats a software write
    always_ff @(posedge clk) begin
        if (reset) begin
            crmd_plv <= '0;
            crmd_ie  <= 1'b0;
        end else if (wb_ex) begin
            crmd_plv <= '0;
            crmd_ie  <= 1'b0;
        end else if (ertn_flush) begin
            crmd_plv <= prmd_pplv;
            crmd_ie  <= prmd_pie;
        end else if (wr_en && csr_id == csr_pkg::ID_CRMD) begin
            crmd_plv <= crmd_wr_val[1:0];
            crmd_ie  <= crmd_wr_val[2];
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            prmd_pplv   <= '0;
            prmd_pie    <= 1'b0;
            era_q       <= '0;
            ecode_rd    <= exc_pkg::INT;
            esubcode_rd <= '0;
        end else if (wb_ex) begin
            prmd_pplv   <= crmd_plv;
            prmd_pie    <= crmd_ie;
            era_q       <= wb_pc;
            ecode_rd    <= wb_ecode;
            esubcode_rd <= wb_esubcode;
        end else if (wr_en) begin
            if (csr_id == csr_pkg::ID_PRMD) begin
                prmd_pplv <= prmd_wr_val[1:0];
                prmd_pie  <= prmd_wr_val[2];
            end
            if (csr_id == csr_pkg::ID_ERA)
                era_q <= csr_pkg::mask_merge(era_q, csr_wvalue, csr_wmask);
        end
    end

    // Entry address is 64-byte aligned
    always_ff @(posedge clk) begin
        if (reset) begin
            eentry_va <= '0;
        end else if (wr_en && csr_id == csr_pkg::ID_EENTRY) begin
            eentry_va <= eentry_wr_val[31:6];
        end
    end

    always_ff @(posedge clk) begin
        for (int i = 0; i < 4; i++) begin
            if (reset) begin
                save_q[i] <= '0;
            end else if (wr_en && csr_id == csr_pkg::csr_id_e'(int'(csr_pkg::ID_SAVE0) + i)) begin
                save_q[i] <= csr_pkg::mask_merge(save_q[i], csr_wvalue, csr_wmask);
            end
        end
    end

endmodule

`default_nettype wire

// File: src/csr_access.sv
`timescale 1ns/10ps
`default_nettype none

`include "csr_settings.svh"

module csr_access (
    input  csr_pkg::csr_num_t  csr_num,
    input  logic               csr_we,
    input  csr_pkg::csr_word_t crmd_rd,
    input  csr_pkg::csr_word_t prmd_rd,
    input  csr_pkg::csr_word_t ecfg_rd,
    input  csr_pkg::csr_word_t estat_rd,
    input  csr_pkg::csr_word_t era_rd,
    input  csr_pkg::csr_word_t eentry_rd,
    input  csr_pkg::csr_word_t save_rd [4],
    input  csr_pkg::csr_word_t tcfg_rd,
    input  csr_pkg::csr_word_t tval_rd,
    output csr_pkg::csr_id_e   csr_id,
    output logic               wr_en,
    output csr_pkg::csr_word_t csr_rvalue
);

    // Single address decode shared by all register blocks
    always_comb begin
        case (csr_num)
            `CSR_ADDR_CRMD:          csr_id = csr_pkg::ID_CRMD;
            `CSR_ADDR_PRMD:          csr_id = csr_pkg::ID_PRMD;
            `CSR_ADDR_ECFG:          csr_id = csr_pkg::ID_ECFG;
            `CSR_ADDR_ESTAT:         csr_id = csr_pkg::ID_ESTAT;
            `CSR_ADDR_ERA:           csr_id = csr_pkg::ID_ERA;
            `CSR_ADDR_EENTRY:        csr_id = csr_pkg::ID_EENTRY;
            `CSR_ADDR_SAVE0:         csr_id = csr_pkg::ID_SAVE0;
            `CSR_ADDR_SAVE0 + 14'd1: csr_id = csr_pkg::ID_SAVE1;
            `CSR_ADDR_SAVE0 + 14'd2: csr_id = csr_pkg::ID_SAVE2;
            `CSR_ADDR_SAVE0 + 14'd3: csr_id = csr_pkg::ID_SAVE3;
            `CSR_ADDR_TCFG:          csr_id = csr_pkg::ID_TCFG;
            `CSR_ADDR_TVAL:          csr_id = csr_pkg::ID_TVAL;
            `CSR_ADDR_TICLR:         csr_id = csr_pkg::ID_TICLR;
            default:                 csr_id = csr_pkg::ID_NONE;
        endcase
    end

    assign wr_en = csr_we && (csr_id != csr_pkg::ID_NONE);

    always_comb begin
        case (csr_id)
            csr_pkg::ID_CRMD:   csr_rvalue = crmd_rd;
            csr_pkg::ID_PRMD:   csr_rvalue = prmd_rd;
            csr_pkg::ID_ECFG:   csr_rvalue = ecfg_rd;
            csr_pkg::ID_ESTAT:  csr_rvalue = estat_rd;
            csr_pkg::ID_ERA:    csr_rvalue = era_rd;
            csr_pkg::ID_EENTRY: csr_rvalue = eentry_rd;
            csr_pkg::ID_SAVE0:  csr_rvalue = save_rd[0];
            csr_pkg::ID_SAVE1:  csr_rvalue = save_rd[1];
            csr_pkg::ID_SAVE2:  csr_rvalue = save_rd[2];
            csr_pkg::ID_SAVE3:  csr_rvalue = save_rd[3];
            csr_pkg::ID_TCFG:   csr_rvalue = tcfg_rd;
            csr_pkg::ID_TVAL:   csr_rvalue = tval_rd;
            // TICLR is write-only, unknown addresses read zero
            default:            csr_rvalue = '0;
        endcase
    end

endmodule

`default_nettype wire

// File: src/exc_pkg.sv
`default_nettype none

package exc_pkg;

    typedef enum logic [5:0] {
        INT  = 6'h00,
        PIL  = 6'h01,
        PIS  = 6'h02,
        PIF  = 6'h03,
        PME  = 6'h04,
        PPI  = 6'h07,
        ADE  = 6'h08,
        ALE  = 6'h09,
        SYS  = 6'h0b,
        BRK  = 6'h0c,
        INE  = 6'h0d,
        IPE  = 6'h0e,
        FPD  = 6'h0f,
        FPE  = 6'h12,
        TLBR = 6'h3f
    } ecode_e;

    typedef logic [8:0] esubcode_t;

endpackage

`default_nettype wire

// File: src/csr_pkg.sv
`default_nettype none

`include "csr_settings.svh"

package csr_pkg;

    typedef logic [`CSR_DATA_W-1:0] csr_word_t;
    typedef logic [`CSR_NUM_W-1:0]  csr_num_t;
    typedef logic [`CSR_IRQ_W-1:0]  irq_vec_t;
    typedef logic [1:0]             plv_t;

    // One identifier per kept register
    typedef enum logic [4:0] {
        ID_NONE,
        ID_CRMD,
        ID_PRMD,
        ID_ECFG,
        ID_ESTAT,
        ID_ERA,
        ID_EENTRY,
        ID_SAVE0,
        ID_SAVE1,
        ID_SAVE2,
        ID_SAVE3,
        ID_TCFG,
        ID_TVAL,
        ID_TICLR
    } csr_id_e;

    // New bits where mask is set, old bits elsewhere
    function automatic csr_word_t mask_merge(
        input csr_word_t old_val,
        input csr_word_t new_val,
        input csr_word_t mask
    );
        return (mask & new_val) | (~mask & old_val);
    endfunction

endpackage

`default_nettype wire

// File: include/csr_settings.svh
`ifndef CSR_SETTINGS_SVH
`define CSR_SETTINGS_SVH

// Widths
`define CSR_NUM_W        14
`define CSR_DATA_W       32
`define CSR_IRQ_W        13
`define CSR_HW_INT_W     8

// Register map
`define CSR_ADDR_CRMD    14'h0000
`define CSR_ADDR_PRMD    14'h0001
`define CSR_ADDR_ECFG    14'h0004
`define CSR_ADDR_ESTAT   14'h0005
`define CSR_ADDR_ERA     14'h0006
`define CSR_ADDR_EENTRY  14'h000c
`define CSR_ADDR_SAVE0   14'h0030
`define CSR_ADDR_TCFG    14'h0041
`define CSR_ADDR_TVAL    14'h0042
`define CSR_ADDR_TICLR   14'h0044

// Counter value for a stopped timer
`define CSR_TIMER_IDLE   32'hffff_ffff

// ESTAT.IS bit positions
`define CSR_IS_TIMER_BIT 11
`define CSR_IS_IPI_BIT   12

`endif
